/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cpu_core
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* alu.sv */
// combinational ALU for the integer core
// twelve operations, unlisted opcodes give zero

`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; #(
    parameter int data_width = data_width_default
) (
    input  alu_op_t               op,
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    output logic [data_width-1:0] y
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shifts only look at the low five bits of b
    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb
    begin
        case (op)
            op_or:
                y = a | b;
            op_and:
                y = a & b;
            op_xor:
                y = a ^ b;
            op_add:
                y = a + b;
            op_sub:
                y = a - b;
            op_shiftl:
                y = a << shamt;
            op_shiftr:
                y = a >> shamt;
            op_not_a:
                y = ~a;
            op_slt:
                y = {{(data_width-1){1'b0}}, lt_signed};
            op_sltu:
                y = {{(data_width-1){1'b0}}, lt_unsigned};
            op_load:
                y = b;
            // upper half from b, lower half of a kept
            op_loadhi:
                y = {b[data_width-const_width-1:0], a[const_width-1:0]};
            default:
                y = '0;
        endcase
    end

endmodule

`default_nettype wire

/* cpu_core.sv */
// top level of the three-stage integer core
// decode, execute and register bank, result exposed on the write-back ports

`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; #(
    parameter int data_width = data_width_default
) (
    input  logic                  clk,
    input  logic                  reset,
    input  instr_t                instr,
    input  logic                  instr_valid,
    output logic                  wb_valid,
    output reg_addr_t             wb_reg,
    output logic [data_width-1:0] wb_data
);

    reg_addr_t             a_reg;
    reg_addr_t             b_reg;
    logic [data_width-1:0] a_data;
    logic [data_width-1:0] b_data;
    logic                  ex_valid;
    alu_op_t               ex_op;
    logic [data_width-1:0] ex_a;
    logic [data_width-1:0] ex_b;
    reg_addr_t             ex_a_reg;
    reg_addr_t             ex_b_reg;
    reg_addr_t             ex_d_reg;
    logic                  ex_we;

    decode_stage #(
        .data_width (data_width)
    ) decode_i (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .a_reg       (a_reg),
        .b_reg       (b_reg),
        .a_data      (a_data),
        .b_data      (b_data),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_a_reg    (ex_a_reg),
        .ex_b_reg    (ex_b_reg),
        .ex_d_reg    (ex_d_reg),
        .ex_we       (ex_we)
    );

    execute_stage #(
        .data_width (data_width)
    ) execute_i (
        .clk      (clk),
        .reset    (reset),
        .ex_valid (ex_valid),
        .ex_op    (ex_op),
        .ex_a     (ex_a),
        .ex_b     (ex_b),
        .ex_a_reg (ex_a_reg),
        .ex_b_reg (ex_b_reg),
        .ex_d_reg (ex_d_reg),
        .ex_we    (ex_we),
        .wb_valid (wb_valid),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data)
    );

    // write port driven straight from the result register
    reg_bank #(
        .data_width (data_width)
    ) reg_bank_i (
        .clk    (clk),
        .reset  (reset),
        .a_reg  (a_reg),
        .b_reg  (b_reg),
        .a_data (a_data),
        .b_data (b_data),
        .d_reg  (wb_reg),
        .d_data (wb_data),
        .we     (wb_valid)
    );

endmodule

`default_nettype wire

/* cpu_pkg.sv */
// shared definitions for the three-stage integer core
// word and register sizes, instruction field positions, classes and ALU opcodes

`default_nettype none

package cpu_pkg;

    localparam int data_width_default = 32;
    localparam int reg_count = 16;
    localparam int const_width = 16;

    typedef logic [3:0]  reg_addr_t;
    typedef logic [31:0] instr_t;

    // instruction field positions
    localparam int class_msb = 31;
    localparam int class_lsb = 28;
    localparam int op_msb    = 27;
    localparam int op_lsb    = 24;
    localparam int const_msb = 23;
    localparam int const_lsb = 8;
    localparam int b_msb     = 11;
    localparam int b_lsb     = 8;
    localparam int a_msb     = 7;
    localparam int a_lsb     = 4;
    localparam int d_msb     = 3;
    localparam int d_lsb     = 0;

    // unlisted class codes act as a nop
    typedef enum logic [3:0] {
        class_nop    = 4'd0,
        class_arith  = 4'd1,
        class_arithc = 4'd2
    } instr_class_t;

    typedef enum logic [3:0] {
        op_or     = 4'b0000,
        op_and    = 4'b0001,
        op_xor    = 4'b0010,
        op_add    = 4'b0011,
        op_sub    = 4'b0100,
        op_shiftl = 4'b0101,
        op_shiftr = 4'b0110,
        op_not_a  = 4'b0111,
        op_slt    = 4'b1000,
        op_sltu   = 4'b1001,
        op_load   = 4'b1100,
        op_loadhi = 4'b1101
    } alu_op_t;

    // upper opcode bits shared by load and loadhi
    localparam logic [2:0] load_group = 3'b110;

endpackage

`default_nettype wire

/* decode_stage.sv */
// decode stage that latches the incoming word, splits its fields,
// reads the register bank and registers the execute operands

`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; #(
    parameter int data_width = data_width_default
) (
    input  logic                  clk,
    input  logic                  reset,
    input  instr_t                instr,
    input  logic                  instr_valid,
    output reg_addr_t             a_reg,
    output reg_addr_t             b_reg,
    input  logic [data_width-1:0] a_data,
    input  logic [data_width-1:0] b_data,
    output logic                  ex_valid,
    output alu_op_t               ex_op,
    output logic [data_width-1:0] ex_a,
    output logic [data_width-1:0] ex_b,
    output reg_addr_t             ex_a_reg,
    output reg_addr_t             ex_b_reg,
    output reg_addr_t             ex_d_reg,
    output logic                  ex_we
);

    instr_t                   instr_q;
    logic                     valid_q;
    instr_class_t             iclass;
    alu_op_t                  op;
    logic [const_width-1:0]   konst;
    logic [data_width-1:0]    konst_ext;
    reg_addr_t                d_reg;
    logic                     use_const;
    logic                     writes;

    // first stage holds the incoming word
    always_ff @(posedge clk)
    begin
        instr_q <= instr;
        if (reset)
            valid_q <= 1'b0;
        else
            valid_q <= instr_valid;
    end

    assign iclass = instr_class_t'(instr_q[class_msb:class_lsb]);
    assign op     = alu_op_t'(instr_q[op_msb:op_lsb]);
    assign konst  = instr_q[const_msb:const_lsb];
    assign a_reg  = instr_q[a_msb:a_lsb];
    assign b_reg  = instr_q[b_msb:b_lsb];
    assign d_reg  = instr_q[d_msb:d_lsb];

    assign use_const = (iclass == class_arithc);
    assign writes    = valid_q && (iclass == class_arith || iclass == class_arithc)
                       && (d_reg != '0);

    // load group takes the constant unsigned, everything else sign extends
    always_comb
    begin
        if (op[3:1] == load_group)
            konst_ext = {{(data_width-const_width){1'b0}}, konst};
        else
            konst_ext = {{(data_width-const_width){konst[const_width-1]}}, konst};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_valid <= 1'b0;
            ex_we    <= 1'b0;
        end
        else
        begin
            ex_valid <= valid_q;
            ex_we    <= writes;
        end
        ex_op    <= op;
        ex_a     <= a_data;
        ex_b     <= use_const ? konst_ext : b_data;
        ex_a_reg <= a_reg;
        // r0 here keeps the constant out of the forwarding compare
        ex_b_reg <= use_const ? reg_addr_t'(0) : b_reg;
        ex_d_reg <= d_reg;
    end

    we_needs_valid: assert property (@(posedge clk) disable iff (reset) ex_we |-> ex_valid)
        else $error("execute write enable without a valid instruction");

endmodule

`default_nettype wire

/* execute_stage.sv */
// execute and result stage
// bypasses from the result register, runs the ALU and holds the write-back result

`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; #(
    parameter int data_width = data_width_default
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ex_valid,
    input  alu_op_t               ex_op,
    input  logic [data_width-1:0] ex_a,
    input  logic [data_width-1:0] ex_b,
    input  reg_addr_t             ex_a_reg,
    input  reg_addr_t             ex_b_reg,
    input  reg_addr_t             ex_d_reg,
    input  logic                  ex_we,
    output logic                  wb_valid,
    output reg_addr_t             wb_reg,
    output logic [data_width-1:0] wb_data
);

    logic                  fwd_a;
    logic                  fwd_b;
    logic [data_width-1:0] op_a;
    logic [data_width-1:0] op_b;
    logic [data_width-1:0] alu_y;

    // the previous instruction sits in the result register
    assign fwd_a = wb_valid && (wb_reg == ex_a_reg) && (ex_a_reg != '0);
    assign fwd_b = wb_valid && (wb_reg == ex_b_reg) && (ex_b_reg != '0);

    assign op_a = fwd_a ? wb_data : ex_a;
    assign op_b = fwd_b ? wb_data : ex_b;

    alu #(
        .data_width (data_width)
    ) alu_i (
        .op (ex_op),
        .a  (op_a),
        .b  (op_b),
        .y  (alu_y)
    );

    // result register that doubles as the write-back stage
    always_ff @(posedge clk)
    begin
        if (reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= ex_valid && ex_we;
        wb_reg  <= ex_d_reg;
        wb_data <= alu_y;
    end

    // a nonzero destination is decided two stages earlier in decode
    wb_dest_nonzero: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> wb_reg != '0)
        else $error("result register targets r0");

endmodule

`default_nettype wire

/* project.f */
cpu_pkg.sv
alu.sv
reg_bank.sv
decode_stage.sv
execute_stage.sv
cpu_core.sv
tb_cpu_core.sv

/* reg_bank.sv */
// register bank, two combinational read ports and one write port
// r0 reads zero, a read of the address being written returns the new data

`timescale 1ns/1ps
`default_nettype none

module reg_bank import cpu_pkg::*; #(
    parameter int data_width = data_width_default
) (
    input  logic                  clk,
    input  logic                  reset,
    input  reg_addr_t             a_reg,
    input  reg_addr_t             b_reg,
    output logic [data_width-1:0] a_data,
    output logic [data_width-1:0] b_data,
    input  reg_addr_t             d_reg,
    input  logic [data_width-1:0] d_data,
    input  logic                  we
);

    logic [data_width-1:0] regs [reg_count];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < reg_count; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && d_reg != '0)
        begin
            regs[d_reg] <= d_data;
        end
    end

    // write-through covers a producer two instructions back
    always_comb
    begin
        if (a_reg == '0)
            a_data = '0;
        else if (we && d_reg == a_reg)
            a_data = d_data;
        else
            a_data = regs[a_reg];
    end

    always_comb
    begin
        if (b_reg == '0)
            b_data = '0;
        else if (we && d_reg == b_reg)
            b_data = d_data;
        else
            b_data = regs[b_reg];
    end

    // decode must have dropped any r0 destination before write-back
    no_r0_write: assert property (@(posedge clk) disable iff (reset) we |-> d_reg != '0)
        else $error("register bank write to r0");

endmodule

`default_nettype wire

/* tb_cpu_core.sv */
// testbench for the three-stage integer core
// shadow register model in issue order, three-deep delay line, checks on the write-back ports

`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core import cpu_pkg::*;;

    localparam int data_width      = data_width_default;
    localparam int clk_period      = 8;
    localparam int reset_cycles    = 16;
    localparam int directed_count  = 160;
    localparam int stream_count    = 400;
    localparam int drain_cycles    = 3;
    localparam int margin_cycles   = 64;
    localparam int watchdog_cycles = reset_cycles + directed_count + stream_count
                                     + drain_cycles + margin_cycles;

    logic                  clk;
    logic                  reset;
    instr_t                instr;
    logic                  instr_valid;
    logic                  wb_valid;
    reg_addr_t             wb_reg;
    logic [data_width-1:0] wb_data;

    // shadow state and the expected result of the instruction being driven
    logic [data_width-1:0] shadow [reg_count];
    logic                  cur_valid;
    reg_addr_t             cur_reg;
    logic [data_width-1:0] cur_data;
    logic                  exp_valid_q [3];
    reg_addr_t             exp_reg_q [3];
    logic [data_width-1:0] exp_data_q [3];
    logic                  armed = 1'b0;
    int                    exp_writes;
    int                    seen_writes;
    string                 test_name;

    cpu_core #(
        .data_width (data_width)
    ) dut_i (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // reference ALU with shifts by b[4:0], signed slt and loadhi keeping the low half of a
    function automatic logic [data_width-1:0] expected_alu(input logic [3:0] op,
            input logic [data_width-1:0] a, input logic [data_width-1:0] b);
        case (op)
            op_or:     return a | b;
            op_and:    return a & b;
            op_xor:    return a ^ b;
            op_add:    return a + b;
            op_sub:    return a - b;
            op_shiftl: return a << b[4:0];
            op_shiftr: return a >> b[4:0];
            op_not_a:  return ~a;
            op_slt:    return ($signed(a) < $signed(b)) ? 1 : 0;
            op_sltu:   return (a < b) ? 1 : 0;
            op_load:   return b;
            op_loadhi: return (b << const_width) | (a & ((1 << const_width) - 1));
            default:   return '0;
        endcase
    endfunction

    function automatic reg_addr_t pick_reg();
        return reg_addr_t'($urandom_range(15, 1));
    endfunction

    // drive one instruction, update the model, move to the next drive slot
    task automatic issue(input logic [3:0] cls, input logic [3:0] op, input reg_addr_t ra,
            input reg_addr_t rb, input reg_addr_t rd, input logic [const_width-1:0] k);
        instr_t                word;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        logic                  writes;
        word = '0;
        word[class_msb:class_lsb] = cls;
        word[op_msb:op_lsb] = op;
        if (cls == class_arithc)
            word[const_msb:const_lsb] = k;
        else
            word[b_msb:b_lsb] = rb;
        word[a_msb:a_lsb] = ra;
        word[d_msb:d_lsb] = rd;
        a = shadow[ra];
        if (cls != class_arithc)
            b = shadow[rb];
        else if (op[3:1] == load_group)
            b = data_width'(k);
        else
            b = data_width'($signed(k));
        writes = (cls == class_arith || cls == class_arithc) && rd != 0;
        instr       = word;
        instr_valid = 1'b1;
        cur_valid   = writes;
        cur_reg     = rd;
        cur_data    = expected_alu(op, a, b);
        if (writes)
        begin
            shadow[rd] = cur_data;
            exp_writes++;
        end
        @(posedge clk);
        #1;
    endtask

    // a bubble carries random bits with instr_valid low
    task automatic bubble(input int count);
        repeat (count)
        begin
            instr       = $urandom;
            instr_valid = 1'b0;
            cur_valid   = 1'b0;
            @(posedge clk);
            #1;
        end
    endtask

    always @(posedge clk)
    begin
        armed <= 1'b1;
        if (reset)
        begin
            exp_valid_q[0] <= 1'b0;
            exp_valid_q[1] <= 1'b0;
            exp_valid_q[2] <= 1'b0;
        end
        else
        begin
            exp_valid_q[0] <= cur_valid;
            exp_valid_q[1] <= exp_valid_q[0];
            exp_valid_q[2] <= exp_valid_q[1];
            if (wb_valid)
                seen_writes++;
        end
        exp_reg_q[0]  <= cur_reg;
        exp_reg_q[1]  <= exp_reg_q[0];
        exp_reg_q[2]  <= exp_reg_q[1];
        exp_data_q[0] <= cur_data;
        exp_data_q[1] <= exp_data_q[0];
        exp_data_q[2] <= exp_data_q[1];
    end

    wb_valid_check: assert property (@(posedge clk) disable iff (!armed)
        wb_valid == exp_valid_q[2])
        else fail_now($sformatf("ERR %s wb_valid expected %b actual %b", test_name,
            $sampled(exp_valid_q[2]), $sampled(wb_valid)));

    wb_reg_check: assert property (@(posedge clk) disable iff (!armed)
        exp_valid_q[2] |-> wb_reg == exp_reg_q[2])
        else fail_now($sformatf("ERR %s wb_reg expected %0d actual %0d", test_name,
            $sampled(exp_reg_q[2]), $sampled(wb_reg)));

    wb_data_check: assert property (@(posedge clk) disable iff (!armed)
        exp_valid_q[2] |-> wb_data == exp_data_q[2])
        else fail_now($sformatf("ERR %s wb_data expected %h actual %h", test_name,
            $sampled(exp_data_q[2]), $sampled(wb_data)));

    initial
    begin
        #(watchdog_cycles * clk_period);
        fail_now("watchdog expired before the test sequence finished");
    end

    initial
    begin
        logic [3:0] cls;
        int         pick;
        void'($urandom(32'h6ba8_8384));
        for (int r = 0; r < reg_count; r++)
            shadow[r] = '0;
        exp_writes  = 0;
        seen_writes = 0;
        test_name   = "reset";
        reset       = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        cur_valid   = 1'b0;
        cur_reg     = '0;
        cur_data    = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        // nothing here may raise wb_valid
        test_name = "idle";
        bubble(3);
        issue(class_nop, op_add, 1, 2, 3, 0);
        issue(4'd7, op_add, 1, 2, 3, 0);
        issue(4'd15, op_load, 1, 2, 4, 0);
        issue(class_arith, op_add, 1, 2, 0, 0);
        issue(class_arithc, op_load, 0, 0, 0, 16'h1234);
        bubble(drain_cycles);

        test_name = "setup";
        for (int r = 1; r < reg_count; r++)
        begin
            issue(class_arithc, op_load, 0, 0, reg_addr_t'(r), 16'($urandom));
            issue(class_arithc, op_loadhi, reg_addr_t'(r), 0, reg_addr_t'(r), 16'($urandom));
        end
        bubble(drain_cycles);

        // all sixteen codes including the unlisted ones
        test_name = "opcodes";
        for (int o = 0; o < 16; o++)
        begin
            issue(class_arith, 4'(o), pick_reg(), pick_reg(), pick_reg(), 0);
            issue(class_arithc, 4'(o), pick_reg(), 0, pick_reg(), 16'($urandom));
        end
        bubble(drain_cycles);

        test_name = "forward";
        issue(class_arith, op_add, 1, 2, 3, 0);
        issue(class_arith, op_sub, 3, 5, 4, 0);
        issue(class_arith, op_xor, 7, 4, 6, 0);
        issue(class_arith, op_add, 6, 6, 8, 0);
        issue(class_arithc, op_add, 9, 0, 9, 16'h0001);
        issue(class_arith, op_or, 10, 11, 12, 0);
        issue(class_arith, op_and, 9, 12, 13, 0);
        issue(class_arithc, op_load, 0, 0, 14, 16'h0a5c);
        bubble(1);
        issue(class_arith, op_add, 14, 14, 15, 0);
        issue(class_arith, op_shiftl, 15, 9, 2, 0);
        bubble(drain_cycles);

        test_name = "const_ext";
        issue(class_arithc, op_add, 1, 0, 2, 16'hfff0);
        issue(class_arithc, op_load, 0, 0, 3, 16'hfff0);
        issue(class_arithc, op_loadhi, 3, 0, 3, 16'hfff0);
        issue(class_arithc, op_sub, 3, 0, 4, 16'h8000);
        issue(class_arithc, op_slt, 2, 0, 5, 16'hffff);
        bubble(drain_cycles);

        test_name = "r0";
        issue(class_arithc, op_load, 0, 0, 0, 16'h1234);
        issue(class_arith, op_add, 0, 0, 5, 0);
        issue(class_arithc, op_or, 0, 0, 6, 16'h00ff);
        issue(class_arith, op_sub, 5, 0, 7, 0);
        bubble(drain_cycles);

        // roughly a quarter bubbles, a few nop and undefined classes
        test_name = "stream";
        for (int n = 0; n < stream_count; n++)
        begin
            if ($urandom_range(3, 0) == 0)
                bubble(1);
            else
            begin
                pick = $urandom_range(9, 0);
                if (pick < 4)
                    cls = class_arith;
                else if (pick < 8)
                    cls = class_arithc;
                else if (pick == 8)
                    cls = class_nop;
                else
                    cls = 4'($urandom_range(15, 3));
                issue(cls, 4'($urandom_range(15, 0)), reg_addr_t'($urandom_range(15, 0)),
                      reg_addr_t'($urandom_range(15, 0)), reg_addr_t'($urandom_range(15, 0)),
                      16'($urandom));
            end
        end
        bubble(drain_cycles + 1);

        if (seen_writes != exp_writes)
            fail_now($sformatf("ERR %s write count expected %0d actual %0d", test_name,
                exp_writes, seen_writes));
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
